// File: hdl/inst_mem_pkg.sv
// Shared AXI response and bank opcode types plus width constants for the instruction memory
package inst_mem_pkg;

  // ----------------------------------------
  // AXI response codes
  // ----------------------------------------
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axi_resp_e;

  // ----------------------------------------
  // Per-bank operation issued by the decoder
  // ----------------------------------------
  typedef enum logic [1:0] {
    BANK_NOP   = 2'b00,
    BANK_READ  = 2'b01,
    BANK_WRITE = 2'b10
  } bank_op_e;

  // Address bits below one 64-bit word
  localparam int BYTE_OFFSET_BITS = 3;

  // Reads in flight, also the response queue size
  localparam int RD_QUEUE_DEPTH = 4;

endpackage

// File: hdl/axil_req_decoder.sv
// AXI4-Lite request decoder inside the top level that range-checks requests and steers bank ops
`timescale 1ns/1ps

module axil_req_decoder #(
  parameter int                    DATA_WIDTH = 64,
  parameter int                    ADDR_WIDTH = 32,
  parameter int                    NUM_BANKS  = 4,
  parameter int                    BANK_DEPTH = 64,
  parameter logic [ADDR_WIDTH-1:0] BASE_ADDR  = 32'h8000_0000
) (
  input  logic                           i_aclk,
  input  logic                           i_rst,
  // Write address and data
  input  logic                           i_awvalid,
  output logic                           o_awready,
  input  logic [ADDR_WIDTH-1:0]          i_awaddr,
  input  logic                           i_wvalid,
  output logic                           o_wready,
  input  logic [DATA_WIDTH-1:0]          i_wdata,
  input  logic [DATA_WIDTH/8-1:0]        i_wstrb,
  // Read address
  input  logic                           i_arvalid,
  output logic                           o_arready,
  input  logic [ADDR_WIDTH-1:0]          i_araddr,
  // Feedback from the merger
  input  logic                           i_rd_pop,
  input  logic                           i_b_done,
  // Bank requests
  output inst_mem_pkg::bank_op_e         o_bank_op [NUM_BANKS],
  output logic [$clog2(BANK_DEPTH)-1:0]  o_bank_index,
  output logic [DATA_WIDTH-1:0]          o_bank_wdata,
  output logic [DATA_WIDTH/8-1:0]        o_bank_wstrb,
  // Read bookkeeping toward the merger
  output logic                           o_rd_push,
  output logic [$clog2(NUM_BANKS)-1:0]   o_rd_bank,
  output logic                           o_rd_err,
  output logic                           o_wr_done_err
);

  localparam int STRB_WIDTH  = DATA_WIDTH / 8;
  localparam int BANK_BITS   = $clog2(NUM_BANKS);
  localparam int INDEX_BITS  = $clog2(BANK_DEPTH);
  localparam int CREDIT_BITS = $clog2(inst_mem_pkg::RD_QUEUE_DEPTH + 1);
  localparam logic [ADDR_WIDTH:0] MEM_BYTES =
    (ADDR_WIDTH+1)'(NUM_BANKS * BANK_DEPTH * STRB_WIDTH);

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_WAIT_RESP,
    WR_RESP_OUT
  } wr_state_e;

  wr_state_e               wr_state;
  logic                    wr_accept;
  logic                    ar_fire;
  logic                    wr_err_q;
  logic [CREDIT_BITS-1:0]  credits;
  logic [ADDR_WIDTH-1:0]   req_addr;
  logic [ADDR_WIDTH-1:0]   req_offset;
  logic                    req_in_range;
  logic [BANK_BITS-1:0]    req_bank;
  logic [INDEX_BITS-1:0]   req_index;
  inst_mem_pkg::bank_op_e  req_op;

  // ----------------------------------------
  // Handshakes with write priority
  // ----------------------------------------
  assign wr_accept = (wr_state == WR_IDLE) && i_awvalid && i_wvalid;
  assign o_awready = wr_accept;
  assign o_wready  = wr_accept;
  assign o_arready = (credits != '0) && !wr_accept;
  assign ar_fire   = i_arvalid && o_arready;

  // One address decoder shared by both request types
  assign req_addr     = wr_accept ? i_awaddr : i_araddr;
  assign req_offset   = req_addr - BASE_ADDR;
  assign req_in_range = (req_addr >= BASE_ADDR) && ({1'b0, req_offset} < MEM_BYTES);
  assign req_bank     = req_offset[inst_mem_pkg::BYTE_OFFSET_BITS +: BANK_BITS];
  assign req_index    = req_offset[inst_mem_pkg::BYTE_OFFSET_BITS + BANK_BITS +: INDEX_BITS];

  assign req_op = wr_accept ? inst_mem_pkg::BANK_WRITE :
                  ar_fire   ? inst_mem_pkg::BANK_READ  : inst_mem_pkg::BANK_NOP;

  // ----------------------------------------
  // Write path FSM
  // ----------------------------------------
  always_ff @(posedge i_aclk) begin
    if (i_rst) begin
      wr_state      <= WR_IDLE;
      o_wr_done_err <= 1'b0;
    end else begin
      // Error writes report in the same slot a bank ack would
      o_wr_done_err <= (wr_state == WR_WAIT_RESP) && wr_err_q;
      case (wr_state)
        WR_IDLE:      if (wr_accept) wr_state <= WR_WAIT_RESP;
        WR_WAIT_RESP: wr_state <= WR_RESP_OUT;
        WR_RESP_OUT:  if (i_b_done) wr_state <= WR_IDLE;
        default:      wr_state <= WR_IDLE;
      endcase
    end
  end

  // One read credit per queue slot
  always_ff @(posedge i_aclk) begin
    if (i_rst) begin
      credits <= CREDIT_BITS'(inst_mem_pkg::RD_QUEUE_DEPTH);
    end else begin
      credits <= credits - CREDIT_BITS'(ar_fire) + CREDIT_BITS'(i_rd_pop);
    end
  end

  // ----------------------------------------
  // Registered bank requests
  // ----------------------------------------
  always_ff @(posedge i_aclk) begin
    for (int b = 0; b < NUM_BANKS; b++) begin
      if (i_rst) begin
        o_bank_op[b] <= inst_mem_pkg::BANK_NOP;
      end else if (req_in_range && (req_bank == BANK_BITS'(b))) begin
        o_bank_op[b] <= req_op;
      end else begin
        o_bank_op[b] <= inst_mem_pkg::BANK_NOP;
      end
    end
  end

  always_ff @(posedge i_aclk) begin
    if (i_rst) begin
      o_rd_push <= 1'b0;
    end else begin
      o_rd_push <= ar_fire;
    end
  end

  always_ff @(posedge i_aclk) begin
    if (wr_accept || ar_fire) begin
      o_bank_index <= req_index;
    end
    if (wr_accept) begin
      o_bank_wdata <= i_wdata;
      o_bank_wstrb <= i_wstrb;
      wr_err_q     <= !req_in_range;
    end
    if (ar_fire) begin
      o_rd_bank <= req_bank;
      o_rd_err  <= !req_in_range;
    end
  end

  // ----------------------------------------
  // Checks
  // ----------------------------------------
  a_credit_bound: assert property (@(posedge i_aclk) disable iff (i_rst)
    credits <= CREDIT_BITS'(inst_mem_pkg::RD_QUEUE_DEPTH));

  // B handshakes only close a write that waits for one
  a_b_done_state: assert property (@(posedge i_aclk) disable iff (i_rst)
    i_b_done |-> (wr_state == WR_RESP_OUT));

endmodule

// File: hdl/sram_bank.sv
// Single SRAM bank with byte-strobed writes and a registered read, instantiated once per bank
`timescale 1ns/1ps

module sram_bank #(
  parameter int DATA_WIDTH = 64,
  parameter int BANK_DEPTH = 64
) (
  input  logic                           i_aclk,
  input  logic                           i_rst,
  input  inst_mem_pkg::bank_op_e         i_op,
  input  logic [$clog2(BANK_DEPTH)-1:0]  i_index,
  input  logic [DATA_WIDTH-1:0]          i_wdata,
  input  logic [DATA_WIDTH/8-1:0]        i_wstrb,
  output logic                           o_rd_valid,
  output logic [DATA_WIDTH-1:0]          o_rd_data,
  output logic                           o_wr_ack
);

  localparam int STRB_WIDTH = DATA_WIDTH / 8;

  logic [DATA_WIDTH-1:0] mem [BANK_DEPTH];
  logic                  do_read;
  logic                  do_write;

  assign do_read  = (i_op == inst_mem_pkg::BANK_READ);
  assign do_write = (i_op == inst_mem_pkg::BANK_WRITE);

  // ----------------------------------------
  // Storage
  // ----------------------------------------
  always_ff @(posedge i_aclk) begin
    if (do_write) begin
      // Only strobed bytes change
      for (int b = 0; b < STRB_WIDTH; b++) begin
        if (i_wstrb[b]) begin
          mem[i_index][8*b +: 8] <= i_wdata[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge i_aclk) begin
    if (do_read) begin
      o_rd_data <= mem[i_index];
    end
  end

  // Status pulses follow the op by one cycle
  always_ff @(posedge i_aclk) begin
    if (i_rst) begin
      o_rd_valid <= 1'b0;
      o_wr_ack   <= 1'b0;
    end else begin
      o_rd_valid <= do_read;
      o_wr_ack   <= do_write;
    end
  end

  // An op always comes with a known word index
  a_index_known: assert property (@(posedge i_aclk) disable iff (i_rst)
    (do_read || do_write) |-> !$isunknown(i_index));

endmodule

// File: hdl/axil_resp_merge.sv
// AXI4-Lite response side: in-order read queue fed by the banks, plus a single write response slot
`timescale 1ns/1ps

module axil_resp_merge #(
  parameter int DATA_WIDTH = 64,
  parameter int NUM_BANKS  = 4
) (
  input  logic                          i_aclk,
  input  logic                          i_rst,
  // From the decoder
  input  logic                          i_rd_push,
  input  logic [$clog2(NUM_BANKS)-1:0]  i_rd_bank,
  input  logic                          i_rd_err,
  input  logic                          i_wr_done_err,
  // From the banks
  input  logic [NUM_BANKS-1:0]          i_bank_rd_valid,
  input  logic [DATA_WIDTH-1:0]         i_bank_rd_data [NUM_BANKS],
  input  logic [NUM_BANKS-1:0]          i_bank_wr_ack,
  // AXI R and B channels
  output logic                          o_rvalid,
  input  logic                          i_rready,
  output logic [DATA_WIDTH-1:0]         o_rdata,
  output inst_mem_pkg::axi_resp_e       o_rresp,
  output logic                          o_bvalid,
  input  logic                          i_bready,
  output inst_mem_pkg::axi_resp_e       o_bresp,
  // Back to the decoder
  output logic                          o_rd_pop,
  output logic                          o_b_done
);

  localparam int DEPTH      = inst_mem_pkg::RD_QUEUE_DEPTH;
  localparam int PTR_BITS   = $clog2(DEPTH);
  localparam int COUNT_BITS = $clog2(DEPTH + 1);
  localparam int BANK_BITS  = $clog2(NUM_BANKS);

  logic [BANK_BITS-1:0]     q_tag  [DEPTH];
  logic [DATA_WIDTH-1:0]    q_data [DEPTH];
  inst_mem_pkg::axi_resp_e  q_resp [DEPTH];
  logic [DEPTH-1:0]         q_filled;
  logic [PTR_BITS-1:0]      wr_ptr;
  logic [PTR_BITS-1:0]      rd_ptr;
  logic [COUNT_BITS-1:0]    count;
  logic [PTR_BITS-1:0]      pend_slot;
  logic                     pend_valid;
  logic                     rd_any;
  logic                     wr_any;

  assign rd_any = |i_bank_rd_valid;
  assign wr_any = |i_bank_wr_ack;

  // ----------------------------------------
  // Read queue
  // ----------------------------------------
  assign o_rvalid = (count != '0) && q_filled[rd_ptr];
  assign o_rdata  = q_data[rd_ptr];
  assign o_rresp  = q_resp[rd_ptr];
  assign o_rd_pop = o_rvalid && i_rready;

  always_ff @(posedge i_aclk) begin
    if (i_rst) begin
      count      <= '0;
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      pend_valid <= 1'b0;
      q_filled   <= '0;
    end else begin
      count      <= count + COUNT_BITS'(i_rd_push) - COUNT_BITS'(o_rd_pop);
      // A good read waits one cycle for its bank
      pend_valid <= i_rd_push && !i_rd_err;
      if (o_rd_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (i_rd_push) begin
        wr_ptr           <= wr_ptr + 1'b1;
        q_filled[wr_ptr] <= i_rd_err;
      end
      if (rd_any) begin
        q_filled[pend_slot] <= 1'b1;
      end
    end
  end

  always_ff @(posedge i_aclk) begin
    if (i_rd_push) begin
      q_tag[wr_ptr]  <= i_rd_bank;
      q_data[wr_ptr] <= '0;
      q_resp[wr_ptr] <= i_rd_err ? inst_mem_pkg::RESP_SLVERR : inst_mem_pkg::RESP_OKAY;
      pend_slot      <= wr_ptr;
    end
    if (rd_any) begin
      q_data[pend_slot] <= i_bank_rd_data[q_tag[pend_slot]];
    end
  end

  // ----------------------------------------
  // Write response
  // ----------------------------------------
  assign o_b_done = o_bvalid && i_bready;

  always_ff @(posedge i_aclk) begin
    if (i_rst) begin
      o_bvalid <= 1'b0;
    end else if (wr_any || i_wr_done_err) begin
      o_bvalid <= 1'b1;
    end else if (o_b_done) begin
      o_bvalid <= 1'b0;
    end
  end

  always_ff @(posedge i_aclk) begin
    if (wr_any || i_wr_done_err) begin
      o_bresp <= wr_any ? inst_mem_pkg::RESP_OKAY : inst_mem_pkg::RESP_SLVERR;
    end
  end

  // ----------------------------------------
  // Checks
  // ----------------------------------------
  a_no_overflow: assert property (@(posedge i_aclk) disable iff (i_rst)
    i_rd_push |-> (count < COUNT_BITS'(DEPTH)));

  a_fill_bank: assert property (@(posedge i_aclk) disable iff (i_rst)
    rd_any |-> (pend_valid &&
                (i_bank_rd_valid == (NUM_BANKS'(1) << q_tag[pend_slot]))));

endmodule

// File: hdl/inst_mem_top.sv
// Banked instruction memory behind one AXI4-Lite slave port, the top level to instantiate
`timescale 1ns/1ps

module inst_mem_top #(
  parameter int                    DATA_WIDTH = 64,
  parameter int                    ADDR_WIDTH = 32,
  parameter int                    NUM_BANKS  = 4,
  parameter int                    BANK_DEPTH = 64,
  parameter logic [ADDR_WIDTH-1:0] BASE_ADDR  = 32'h8000_0000
) (
  input  logic                     i_aclk,
  input  logic                     i_rst,
  // AW and W
  input  logic                     i_awvalid,
  output logic                     o_awready,
  input  logic [ADDR_WIDTH-1:0]    i_awaddr,
  input  logic                     i_wvalid,
  output logic                     o_wready,
  input  logic [DATA_WIDTH-1:0]    i_wdata,
  input  logic [DATA_WIDTH/8-1:0]  i_wstrb,
  // B
  output logic                     o_bvalid,
  input  logic                     i_bready,
  output inst_mem_pkg::axi_resp_e  o_bresp,
  // AR
  input  logic                     i_arvalid,
  output logic                     o_arready,
  input  logic [ADDR_WIDTH-1:0]    i_araddr,
  // R
  output logic                     o_rvalid,
  input  logic                     i_rready,
  output logic [DATA_WIDTH-1:0]    o_rdata,
  output inst_mem_pkg::axi_resp_e  o_rresp
);

  localparam int STRB_WIDTH = DATA_WIDTH / 8;
  localparam int BANK_BITS  = $clog2(NUM_BANKS);
  localparam int INDEX_BITS = $clog2(BANK_DEPTH);

  // ----------------------------------------
  // Internal connections
  // ----------------------------------------
  inst_mem_pkg::bank_op_e  bank_op [NUM_BANKS];
  logic [INDEX_BITS-1:0]   bank_index;
  logic [DATA_WIDTH-1:0]   bank_wdata;
  logic [STRB_WIDTH-1:0]   bank_wstrb;
  logic [NUM_BANKS-1:0]    bank_rd_valid;
  logic [DATA_WIDTH-1:0]   bank_rd_data [NUM_BANKS];
  logic [NUM_BANKS-1:0]    bank_wr_ack;
  logic                    rd_push;
  logic [BANK_BITS-1:0]    rd_bank;
  logic                    rd_err;
  logic                    wr_done_err;
  logic                    rd_pop;
  logic                    b_done;

  axil_req_decoder #(
    .DATA_WIDTH (DATA_WIDTH),
    .ADDR_WIDTH (ADDR_WIDTH),
    .NUM_BANKS  (NUM_BANKS),
    .BANK_DEPTH (BANK_DEPTH),
    .BASE_ADDR  (BASE_ADDR)
  ) u_req_decoder (
    .i_aclk        (i_aclk),
    .i_rst         (i_rst),
    .i_awvalid     (i_awvalid),
    .o_awready     (o_awready),
    .i_awaddr      (i_awaddr),
    .i_wvalid      (i_wvalid),
    .o_wready      (o_wready),
    .i_wdata       (i_wdata),
    .i_wstrb       (i_wstrb),
    .i_arvalid     (i_arvalid),
    .o_arready     (o_arready),
    .i_araddr      (i_araddr),
    .i_rd_pop      (rd_pop),
    .i_b_done      (b_done),
    .o_bank_op     (bank_op),
    .o_bank_index  (bank_index),
    .o_bank_wdata  (bank_wdata),
    .o_bank_wstrb  (bank_wstrb),
    .o_rd_push     (rd_push),
    .o_rd_bank     (rd_bank),
    .o_rd_err      (rd_err),
    .o_wr_done_err (wr_done_err)
  );

  // Word-interleaved banks
  for (genvar g = 0; g < NUM_BANKS; g++) begin : gen_bank
    sram_bank #(
      .DATA_WIDTH (DATA_WIDTH),
      .BANK_DEPTH (BANK_DEPTH)
    ) u_sram_bank (
      .i_aclk     (i_aclk),
      .i_rst      (i_rst),
      .i_op       (bank_op[g]),
      .i_index    (bank_index),
      .i_wdata    (bank_wdata),
      .i_wstrb    (bank_wstrb),
      .o_rd_valid (bank_rd_valid[g]),
      .o_rd_data  (bank_rd_data[g]),
      .o_wr_ack   (bank_wr_ack[g])
    );
  end

  axil_resp_merge #(
    .DATA_WIDTH (DATA_WIDTH),
    .NUM_BANKS  (NUM_BANKS)
  ) u_resp_merge (
    .i_aclk          (i_aclk),
    .i_rst           (i_rst),
    .i_rd_push       (rd_push),
    .i_rd_bank       (rd_bank),
    .i_rd_err        (rd_err),
    .i_wr_done_err   (wr_done_err),
    .i_bank_rd_valid (bank_rd_valid),
    .i_bank_rd_data  (bank_rd_data),
    .i_bank_wr_ack   (bank_wr_ack),
    .o_rvalid        (o_rvalid),
    .i_rready        (i_rready),
    .o_rdata         (o_rdata),
    .o_rresp         (o_rresp),
    .o_bvalid        (o_bvalid),
    .i_bready        (i_bready),
    .o_bresp         (o_bresp),
    .o_rd_pop        (rd_pop),
    .o_b_done        (b_done)
  );

endmodule

// File: testbench/tb_inst_mem.sv
// Testbench for the banked instruction memory that plays the trace file and checks R and B responses
`timescale 1ns/1ps

module tb_inst_mem;

  localparam int DATA_WIDTH = 64;
  localparam int ADDR_WIDTH = 32;
  localparam int MAX_LINES  = 128;

  logic                     i_aclk;
  logic                     i_rst;
  logic                     i_awvalid;
  logic                     o_awready;
  logic [ADDR_WIDTH-1:0]    i_awaddr;
  logic                     i_wvalid;
  logic                     o_wready;
  logic [DATA_WIDTH-1:0]    i_wdata;
  logic [DATA_WIDTH/8-1:0]  i_wstrb;
  logic                     o_bvalid;
  logic                     i_bready;
  inst_mem_pkg::axi_resp_e  o_bresp;
  logic                     i_arvalid;
  logic                     o_arready;
  logic [ADDR_WIDTH-1:0]    i_araddr;
  logic                     o_rvalid;
  logic                     i_rready;
  logic [DATA_WIDTH-1:0]    o_rdata;
  inst_mem_pkg::axi_resp_e  o_rresp;

  // One trace entry per transaction
  int                       line_count;
  int                       tr_test  [MAX_LINES];
  logic [7:0]               tr_op    [MAX_LINES];
  logic [ADDR_WIDTH-1:0]    tr_addr  [MAX_LINES];
  logic [DATA_WIDTH-1:0]    tr_wdata [MAX_LINES];
  logic [7:0]               tr_wstrb [MAX_LINES];
  logic [DATA_WIDTH-1:0]    tr_rdata [MAX_LINES];
  inst_mem_pkg::axi_resp_e  tr_resp  [MAX_LINES];

  // Expected responses in request order
  logic [DATA_WIDTH-1:0]    rd_exp_data [$];
  inst_mem_pkg::axi_resp_e  rd_exp_resp [$];
  inst_mem_pkg::axi_resp_e  b_exp_resp  [$];
  logic [DATA_WIDTH-1:0]    got_data;
  inst_mem_pkg::axi_resp_e  got_resp;

  integer seed = 24062;
  int     errors = 0;
  int     base_errors = 0;
  int     tests_run = 0;
  int     tests_failed = 0;
  int     cycles = 0;
  int     cycle_limit = 100;
  int     inflight = 0;
  int     max_inflight = 0;
  logic   bp_enable = 1'b0;
  logic   bready_rand = 1'b0;
  logic   hold_bready = 1'b0;

  assign i_bready = bready_rand && !hold_bready;

  inst_mem_top #(
    .DATA_WIDTH (DATA_WIDTH),
    .ADDR_WIDTH (ADDR_WIDTH)
  ) inst_mem_top_inst (
    .i_aclk    (i_aclk),
    .i_rst     (i_rst),
    .i_awvalid (i_awvalid),
    .o_awready (o_awready),
    .i_awaddr  (i_awaddr),
    .i_wvalid  (i_wvalid),
    .o_wready  (o_wready),
    .i_wdata   (i_wdata),
    .i_wstrb   (i_wstrb),
    .o_bvalid  (o_bvalid),
    .i_bready  (i_bready),
    .o_bresp   (o_bresp),
    .i_arvalid (i_arvalid),
    .o_arready (o_arready),
    .i_araddr  (i_araddr),
    .o_rvalid  (o_rvalid),
    .i_rready  (i_rready),
    .o_rdata   (o_rdata),
    .o_rresp   (o_rresp)
  );

  initial begin
    i_aclk = 1'b0;
    forever #50 i_aclk = ~i_aclk;
  end

  // ----------------------------------------
  // Watchdog and random back-pressure
  // ----------------------------------------
  always @(posedge i_aclk) begin
    cycles = cycles + 1;
    bp_enable = !i_rst;
    if (cycles > cycle_limit) begin
      $display("timeout after %0d cycles, %0d reads and %0d writes never got a response",
               cycles, rd_exp_data.size(), b_exp_resp.size());
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // Roughly 70 percent ready on R and B
  always @(negedge i_aclk) begin
    if (bp_enable) begin
      i_rready    = ({$random(seed)} % 100) < 70;
      bready_rand = ({$random(seed)} % 100) < 70;
    end
  end

  // ----------------------------------------
  // Response checks on the rising edge
  // ----------------------------------------
  always @(posedge i_aclk) begin
    if (!i_rst) begin
      assert (!(o_arready && inflight >= inst_mem_pkg::RD_QUEUE_DEPTH)) else begin
        $display("mismatch at %0t: ARREADY high with %0d reads in flight", $time, inflight);
        errors++;
      end
      if (o_rvalid && i_rready) begin
        inflight--;
        assert (rd_exp_data.size() != 0) else begin
          $display("R response at %0t arrived with no read outstanding", $time);
          errors++;
        end
        if (rd_exp_data.size() != 0) begin
          got_data = rd_exp_data.pop_front();
          got_resp = rd_exp_resp.pop_front();
          assert (o_rdata === got_data && o_rresp === got_resp) else begin
            $display("mismatch at %0t: read gave %h resp %0d, expected %h resp %0d",
                     $time, o_rdata, o_rresp, got_data, got_resp);
            errors++;
          end
        end
      end
      if (i_arvalid && o_arready) begin
        inflight++;
        if (inflight > max_inflight) begin
          max_inflight = inflight;
        end
      end
      if (o_bvalid && i_bready) begin
        assert (b_exp_resp.size() != 0) else begin
          $display("B response at %0t arrived with no write outstanding", $time);
          errors++;
        end
        if (b_exp_resp.size() != 0) begin
          got_resp = b_exp_resp.pop_front();
          assert (o_bresp === got_resp) else begin
            $display("mismatch at %0t: write resp %0d, expected %0d", $time, o_bresp, got_resp);
            errors++;
          end
        end
      end
    end
  end

  // ----------------------------------------
  // Trace loading
  // ----------------------------------------
  task automatic load_trace();
    int                    fd;
    int                    n;
    logic [8*160-1:0]      line_buf;
    logic [7:0]            op_tok;
    logic [8*8-1:0]        resp_tok;
    fd = $fopen("testbench/inst_mem_trace.txt", "r");
    line_count = 0;
    if (fd == 0) begin
      $display("the trace file testbench/inst_mem_trace.txt could not be opened");
    end else begin
      line_buf = '0;
      while ($fgets(line_buf, fd) != 0 && line_count < MAX_LINES) begin
        // Comment and blank lines fail the scan and are skipped
        n = $sscanf(line_buf, "%d %s %h %h %h %h %s", tr_test[line_count], op_tok,
                    tr_addr[line_count], tr_wdata[line_count], tr_wstrb[line_count],
                    tr_rdata[line_count], resp_tok);
        if (n == 7) begin
          tr_op[line_count]   = op_tok;
          tr_resp[line_count] = (resp_tok == "OKAY") ? inst_mem_pkg::RESP_OKAY
                                                     : inst_mem_pkg::RESP_SLVERR;
          assert (tr_addr[line_count][inst_mem_pkg::BYTE_OFFSET_BITS-1:0] == '0) else begin
            $display("trace entry %0d has an address that is not word aligned", line_count);
            errors++;
          end
          line_count++;
        end
        line_buf = '0;
      end
      $fclose(fd);
    end
  endtask

  // ----------------------------------------
  // Bus drivers entered on a falling edge
  // ----------------------------------------
  task automatic issue_read(input int idx);
    i_arvalid = 1'b1;
    i_araddr  = tr_addr[idx];
    @(posedge i_aclk);
    while (!o_arready) @(posedge i_aclk);
    rd_exp_data.push_back(tr_rdata[idx]);
    rd_exp_resp.push_back(tr_resp[idx]);
    @(negedge i_aclk);
    i_arvalid = 1'b0;
    // Release a held B once this read has come back
    if (hold_bready) begin
      while (rd_exp_data.size() != 0) @(negedge i_aclk);
      hold_bready = 1'b0;
    end
  endtask

  task automatic issue_write(input int idx, input logic hold);
    i_awvalid = 1'b1;
    i_wvalid  = 1'b1;
    i_awaddr  = tr_addr[idx];
    i_wdata   = tr_wdata[idx];
    i_wstrb   = tr_wstrb[idx];
    @(posedge i_aclk);
    while (!(o_awready || o_wready)) @(posedge i_aclk);
    assert (o_awready === o_wready) else begin
      $display("mismatch at %0t: AWREADY %b and WREADY %b differ", $time, o_awready, o_wready);
      errors++;
    end
    b_exp_resp.push_back(tr_resp[idx]);
    @(negedge i_aclk);
    i_awvalid = 1'b0;
    i_wvalid  = 1'b0;
    hold_bready = hold;
  endtask

  task automatic report_test(input int id);
    while (rd_exp_data.size() != 0 || b_exp_resp.size() != 0) @(negedge i_aclk);
    tests_run++;
    if (errors == base_errors) begin
      $display("test %0d: ok", id);
    end else begin
      tests_failed++;
      $display("test %0d: failed with %0d errors", id, errors - base_errors);
    end
    base_errors = errors;
  endtask

  task automatic run_trace();
    int idx;
    int cur_test;
    repeat (2) @(posedge i_aclk);
    @(negedge i_aclk);
    i_rst = 1'b0;
    @(posedge i_aclk);
    assert (!o_rvalid && !o_bvalid && o_arready) else begin
      $display("mismatch at %0t: after reset RVALID %b BVALID %b ARREADY %b",
               $time, o_rvalid, o_bvalid, o_arready);
      errors++;
    end
    @(negedge i_aclk);
    cur_test = tr_test[0];
    for (idx = 0; idx < line_count; idx++) begin
      if (tr_test[idx] != cur_test) begin
        report_test(cur_test);
        cur_test = tr_test[idx];
      end
      case (tr_op[idx])
        "R":     issue_read(idx);
        "W":     issue_write(idx, 1'b0);
        "P":     issue_write(idx, 1'b1);
        default: begin
          $display("trace entry %0d has an unknown operation", idx);
          errors++;
        end
      endcase
    end
    report_test(cur_test);
    assert (max_inflight > 1) else begin
      $display("reads were never pipelined, at most one was in flight");
      errors++;
    end
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin
    i_rst     = 1'b1;
    i_awvalid = 1'b0;
    i_awaddr  = '0;
    i_wvalid  = 1'b0;
    i_wdata   = '0;
    i_wstrb   = '0;
    i_arvalid = 1'b0;
    i_araddr  = '0;
    i_rready  = 1'b0;
    load_trace();
    cycle_limit = line_count * 20 + 100;
    if (line_count == 0) begin
      $display("no transactions were read from the trace file");
      $display("STATUS: FAIL");
      $finish;
    end else begin
      run_trace();
      $display("tests run %0d, passed %0d, failed %0d, errors %0d",
               tests_run, tests_run - tests_failed, tests_failed, errors);
      if (errors == 0) begin
        $display("STATUS: PASS");
      end else begin
        $display("STATUS: FAIL");
      end
      $finish;
    end
  end

endmodule

// File: list.f
hdl/inst_mem_pkg.sv
hdl/axil_req_decoder.sv
hdl/sram_bank.sv
hdl/axil_resp_merge.sv
hdl/inst_mem_top.sv
testbench/tb_inst_mem.sv

// File: testbench/inst_mem_trace.txt
# Columns: test id, op (W write, P write with BREADY held low, R read), address,
# write data, write strobe, expected read data, expected response (OKAY or SLVERR)
# Memory spans 0x80000000 to 0x800007ff, bank = addr[4:3], index = addr[10:5]
1 W 80000000 0123456789abcdef ff 0000000000000000 OKAY
1 R 80000000 0000000000000000 00 0123456789abcdef OKAY
2 W 80000008 1111111111111111 ff 0000000000000000 OKAY
2 W 80000008 aabbccddeeff0011 0f 0000000000000000 OKAY
2 W 80000008 2233445566778899 a0 0000000000000000 OKAY
2 R 80000008 0000000000000000 00 22114411eeff0011 OKAY
2 W 80000008 ffffffffffffffff 00 0000000000000000 OKAY
2 R 80000008 0000000000000000 00 22114411eeff0011 OKAY
3 W 80000100 cafe000080000100 ff 0000000000000000 OKAY
3 W 80000108 cafe000180000108 ff 0000000000000000 OKAY
3 W 80000110 cafe000280000110 ff 0000000000000000 OKAY
3 W 80000118 cafe000380000118 ff 0000000000000000 OKAY
3 W 80000120 cafe000480000120 ff 0000000000000000 OKAY
3 W 80000128 cafe000580000128 ff 0000000000000000 OKAY
3 W 80000130 cafe000680000130 ff 0000000000000000 OKAY
3 W 80000138 cafe000780000138 ff 0000000000000000 OKAY
3 R 80000100 0000000000000000 00 cafe000080000100 OKAY
3 R 80000108 0000000000000000 00 cafe000180000108 OKAY
3 R 80000110 0000000000000000 00 cafe000280000110 OKAY
3 R 80000118 0000000000000000 00 cafe000380000118 OKAY
3 R 80000120 0000000000000000 00 cafe000480000120 OKAY
3 R 80000128 0000000000000000 00 cafe000580000128 OKAY
3 R 80000130 0000000000000000 00 cafe000680000130 OKAY
3 R 80000138 0000000000000000 00 cafe000780000138 OKAY
3 R 80000138 0000000000000000 00 cafe000780000138 OKAY
3 R 80000100 0000000000000000 00 cafe000080000100 OKAY
4 R 7ffffff8 0000000000000000 00 0000000000000000 SLVERR
4 R 80000800 0000000000000000 00 0000000000000000 SLVERR
4 W 80000010 5555aaaa5555aaaa ff 0000000000000000 OKAY
4 W 80000810 deadbeefdeadbeef ff 0000000000000000 SLVERR
4 W fffffff8 0badf00d0badf00d ff 0000000000000000 SLVERR
4 R 80000010 0000000000000000 00 5555aaaa5555aaaa OKAY
5 W 80000200 0000000011111111 ff 0000000000000000 OKAY
5 P 80000200 9999888877776666 ff 0000000000000000 OKAY
5 R 80000200 0000000000000000 00 9999888877776666 OKAY
5 W 80000218 7777777777777777 ff 0000000000000000 OKAY
5 P 80000218 0123012301230123 33 0000000000000000 OKAY
5 R 80000218 0000000000000000 00 7777012377770123 OKAY
